//--- Makefile
# Verilator build and run for the trigger timer target

VERILATOR ?= verilator
TOP       ?= tb_trigger_target
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+verification
source/trigger_target_pkg.sv
source/host_bus_frontend.sv
source/trigger_reg_bank.sv
source/pulse_timer.sv
source/trigger_collector.sv
source/trigger_target_top.sv
verification/tb_trigger_target.sv

//--- source/host_bus_frontend.sv
// ################################################
// Host bus front end
// Synchronizes the parallel host strobes and makes
// one-cycle register read and write strobes
// ################################################
`timescale 1ns/100ps

module host_bus_frontend (
    input  logic                                      pll_clk1,
    input  logic                                      rst_n,
    input  logic [trigger_target_pkg::ADDR_WIDTH-1:0] usb_addr,
    input  logic [7:0]                                usb_din,
    input  logic                                      usb_rdn,
    input  logic                                      usb_wrn,
    input  logic                                      usb_cen,
    input  logic [7:0]                                read_data,  // From register bank
    output logic [7:0]                                usb_dout,
    output logic                                      usb_isout,
    output trigger_target_pkg::reg_access_t           access
);

    logic [1:0] cen_sync;                                   // Two-flop synchronizers
    logic [1:0] wrn_sync;
    logic [1:0] rdn_sync;
    logic       wr_en;
    logic       rd_en;
    logic       wr_en_d;
    logic       rd_en_d;
    logic       wr_edge;
    logic       rd_edge;
    logic       wr_pulse;
    logic       rd_pulse;
    trigger_target_pkg::reg_addr_t addr_q;
    trigger_target_pkg::bytecnt_t  bytecnt_q;
    logic [7:0] wdata_q;

    always_ff @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n) begin
            cen_sync <= 2'b11;                              // Strobes idle high
            wrn_sync <= 2'b11;
            rdn_sync <= 2'b11;
        end else begin
            cen_sync <= {cen_sync[0], usb_cen};
            wrn_sync <= {wrn_sync[0], usb_wrn};
            rdn_sync <= {rdn_sync[0], usb_rdn};
        end
    end

    assign wr_en   = ~cen_sync[1] & ~wrn_sync[1];
    assign rd_en   = ~cen_sync[1] & ~rdn_sync[1];
    assign wr_edge = wr_en & ~wr_en_d;                      // First cycle of access
    assign rd_edge = rd_en & ~rd_en_d;

    always_ff @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_d  <= 1'b0;
            rd_en_d  <= 1'b0;
            wr_pulse <= 1'b0;
            rd_pulse <= 1'b0;
        end else begin
            wr_en_d  <= wr_en;
            rd_en_d  <= rd_en;
            wr_pulse <= wr_edge;                            // 3 cycles after input edge
            rd_pulse <= rd_edge;
        end
    end

    // Host keeps address and data stable, so capture on the edge
    always_ff @(posedge pll_clk1) begin
        if (wr_edge || rd_edge) begin
            addr_q    <= usb_addr[trigger_target_pkg::ADDR_WIDTH-1:trigger_target_pkg::BYTECNT_SIZE];
            bytecnt_q <= usb_addr[trigger_target_pkg::BYTECNT_SIZE-1:0];
            wdata_q   <= usb_din;
        end
    end

    always_comb begin
        access.address = addr_q;
        access.bytecnt = bytecnt_q;
        access.wdata   = wdata_q;
        access.read    = rd_pulse;
        access.write   = wr_pulse;
    end

    assign usb_isout = rd_en;                               // Drive bus while read held
    assign usb_dout  = usb_isout ? read_data : 8'h00;

    a_rd_wr_excl: assert property (@(posedge pll_clk1) disable iff (!rst_n)
        !(rd_pulse && wr_pulse));

endmodule

//--- source/pulse_timer.sv
// ################################################
// Pulse timer
// Down-counter that fires one pulse at zero, then
// reloads or goes idle by mode
// ################################################
`timescale 1ns/100ps

module pulse_timer (
    input  logic                           pll_clk1,
    input  logic                           rst_n,
    input  trigger_target_pkg::timer_cmd_t cmd,
    output logic                           fire
);

    trigger_target_pkg::timer_state_e          state;
    logic [trigger_target_pkg::COUNT_WIDTH-1:0] count;

    // Fires reload+1 cycles after the start pulse
    assign fire = (state == trigger_target_pkg::TIMER_RUN) && (count == '0);

    always_ff @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n) begin
            state <= trigger_target_pkg::TIMER_IDLE;
            count <= '0;
        end else if (cmd.stop) begin
            state <= trigger_target_pkg::TIMER_IDLE;       // Abort at once
        end else if (cmd.start) begin
            state <= trigger_target_pkg::TIMER_RUN;        // Restart even if running
            count <= cmd.reload;
        end else if (fire) begin
            if (cmd.mode == trigger_target_pkg::TIMER_PERIODIC)
                count <= cmd.reload;                        // Next period
            else
                state <= trigger_target_pkg::TIMER_IDLE;   // One-shot done
        end else if (state == trigger_target_pkg::TIMER_RUN) begin
            count <= count - 1'b1;
        end
    end

endmodule

//--- source/trigger_collector.sv
// ################################################
// Trigger collector
// Merges timer fires into the trigger output, the
// sticky status bits, fire counts and the LED
// ################################################
`timescale 1ns/100ps

module trigger_collector #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                      pll_clk1,
    input  logic                      rst_n,
    input  logic [NUM_TIMERS-1:0]      fire,
    input  logic [NUM_TIMERS-1:0]      status_clear,
    output logic [NUM_TIMERS-1:0]      status,
    output logic [NUM_TIMERS-1:0][7:0] fire_count,
    output logic                      tio_trigger,
    output logic                      led
);

    always_ff @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n) begin
            status      <= '0;
            fire_count  <= '0;
            tio_trigger <= 1'b0;
        end else begin
            status      <= (status & ~status_clear) | fire; // Fire beats clear
            tio_trigger <= |fire;                           // One cycle after fire
            for (int n = 0; n < NUM_TIMERS; n++) begin
                if (fire[n])
                    fire_count[n] <= fire_count[n] + 8'd1;  // Wraps at 255
            end
        end
    end

    assign led = |status;                                   // Any sticky bit pending

endmodule

//--- source/trigger_reg_bank.sv
// ################################################
// Trigger register bank
// Identity, status, reload and control registers,
// timer command lanes and the read multiplexer
// ################################################
`timescale 1ns/100ps

module trigger_reg_bank #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                                              pll_clk1,
    input  logic                                              rst_n,
    input  trigger_target_pkg::reg_access_t                   access,
    input  logic [NUM_TIMERS-1:0]                             status,
    input  logic [NUM_TIMERS-1:0][7:0]                        fire_count,
    output logic [7:0]                                        read_data,
    output trigger_target_pkg::timer_cmd_t [NUM_TIMERS-1:0]   timer_cmd,
    output logic [NUM_TIMERS-1:0]                             status_clear
);

    logic [NUM_TIMERS-1:0][trigger_target_pkg::COUNT_WIDTH-1:0] reload_q;
    logic [NUM_TIMERS-1:0] mode_q;                          // Per-timer mode bit
    logic [NUM_TIMERS-1:0] reload_sel;                      // Address decodes
    logic [NUM_TIMERS-1:0] ctrl_sel;
    logic [NUM_TIMERS-1:0] count_sel;
    logic [NUM_TIMERS-1:0] start_hit;
    logic [NUM_TIMERS-1:0] stop_hit;
    logic                  byte0;
    logic                  byte1;
    logic                  status_sel;
    logic [7:0]            rd_mux;

    assign byte0      = access.bytecnt == 0;
    assign byte1      = access.bytecnt == 1;
    assign status_sel = access.address == trigger_target_pkg::REG_STATUS;

    // W1C of the sticky bits
    assign status_clear = (access.write && status_sel && byte0) ?
                          access.wdata[NUM_TIMERS-1:0] : '0;

    for (genvar n = 0; n < NUM_TIMERS; n++) begin : g_lane
        assign reload_sel[n] = access.address ==
            trigger_target_pkg::reg_addr_t'(trigger_target_pkg::REG_RELOAD_BASE + n);
        assign ctrl_sel[n] = access.address ==
            trigger_target_pkg::reg_addr_t'(trigger_target_pkg::REG_CTRL_BASE + n);
        assign count_sel[n] = access.address ==
            trigger_target_pkg::reg_addr_t'(trigger_target_pkg::REG_COUNT_BASE + n);

        assign stop_hit[n]  = access.write && ctrl_sel[n] && byte0 &&
                              access.wdata[trigger_target_pkg::CTRL_STOP_BIT];
        assign start_hit[n] = access.write && ctrl_sel[n] && byte0 &&
                              access.wdata[trigger_target_pkg::CTRL_START_BIT] &&
                              !access.wdata[trigger_target_pkg::CTRL_STOP_BIT]; // Stop wins

        assign timer_cmd[n] = '{reload: reload_q[n],
                                mode:   trigger_target_pkg::timer_mode_e'(mode_q[n]),
                                start:  start_hit[n],
                                stop:   stop_hit[n]};

        a_start_single: assert property (@(posedge pll_clk1) disable iff (!rst_n)
            timer_cmd[n].start |=> !timer_cmd[n].start);
        a_stop_single: assert property (@(posedge pll_clk1) disable iff (!rst_n)
            timer_cmd[n].stop |=> !timer_cmd[n].stop);
    end

    always_ff @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n) begin
            reload_q <= '0;
            mode_q   <= '0;
        end else if (access.write) begin
            for (int n = 0; n < NUM_TIMERS; n++) begin
                if (reload_sel[n] && byte0) reload_q[n][7:0]  <= access.wdata; // Little endian
                if (reload_sel[n] && byte1) reload_q[n][15:8] <= access.wdata;
                if (ctrl_sel[n] && byte0)
                    mode_q[n] <= access.wdata[trigger_target_pkg::CTRL_MODE_BIT];
            end
        end
    end

    always_comb begin
        rd_mux = 8'h00;                                     // Unmapped reads 0
        if (access.address == trigger_target_pkg::REG_IDENT && byte0)
            rd_mux = trigger_target_pkg::IDENT_VALUE;
        if (status_sel && byte0)
            rd_mux[NUM_TIMERS-1:0] = status;
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (reload_sel[n] && byte0) rd_mux = reload_q[n][7:0];
            if (reload_sel[n] && byte1) rd_mux = reload_q[n][15:8];
            if (ctrl_sel[n] && byte0)   rd_mux = {5'b00000, mode_q[n], 2'b00}; // Pulses read 0
            if (count_sel[n] && byte0)  rd_mux = fire_count[n];
        end
    end

    always_ff @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n)
            read_data <= 8'h00;
        else if (access.read)
            read_data <= rd_mux;                            // One cycle after read strobe
    end

endmodule

//--- source/trigger_target_pkg.sv
// ################################################
// Trigger timer target shared definitions
// Bus widths, register map, timer types and the
// structs passed between the blocks
// ################################################
package trigger_target_pkg;

    // Host bus geometry
    parameter int ADDR_WIDTH     = 32;                      // Full host address
    parameter int BYTECNT_SIZE   = 8;                       // Byte select within a register
    parameter int REG_ADDR_WIDTH = ADDR_WIDTH - BYTECNT_SIZE; // Register index width
    parameter int COUNT_WIDTH    = 16;                      // Timer reload, two bytes

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [BYTECNT_SIZE-1:0]   bytecnt_t;

    // Register map, register index space
    parameter reg_addr_t REG_IDENT       = 'h00;            // Read-only identity
    parameter reg_addr_t REG_STATUS      = 'h01;            // Sticky fire bits, W1C
    parameter reg_addr_t REG_RELOAD_BASE = 'h10;            // Reload of timer n, 2 bytes
    parameter reg_addr_t REG_CTRL_BASE   = 'h20;            // Start, stop, mode of timer n
    parameter reg_addr_t REG_COUNT_BASE  = 'h30;            // Fire count of timer n

    parameter logic [7:0] IDENT_VALUE = 8'h5A;

    // Control register bit positions
    parameter int CTRL_START_BIT = 0;                       // Self-clearing
    parameter int CTRL_STOP_BIT  = 1;                       // Self-clearing, wins over start
    parameter int CTRL_MODE_BIT  = 2;

    typedef enum logic {
        TIMER_ONESHOT  = 1'b0,                              // Idle after one fire
        TIMER_PERIODIC = 1'b1                               // Reload on fire
    } timer_mode_e;

    typedef enum logic {
        TIMER_IDLE = 1'b0,
        TIMER_RUN  = 1'b1
    } timer_state_e;

    // One register access from the host front end
    typedef struct packed {
        reg_addr_t  address;                                // Register index
        bytecnt_t   bytecnt;                                // Byte within register
        logic [7:0] wdata;                                  // Write byte
        logic       read;                                   // One-cycle read strobe
        logic       write;                                  // One-cycle write strobe
    } reg_access_t;

    // Command lane from the register bank to one timer
    typedef struct packed {
        logic [COUNT_WIDTH-1:0] reload;                     // Level
        timer_mode_e            mode;                       // Level
        logic                   start;                      // Pulse
        logic                   stop;                       // Pulse
    } timer_cmd_t;

endpackage

//--- source/trigger_target_top.sv
// ################################################
// Trigger timer target top level
// Host bus front end, register bank, timer lanes
// and trigger collector
// ################################################
`timescale 1ns/100ps

module trigger_target_top #(
    parameter int NUM_TIMERS = 4                            // 1 to 8, status is one byte
) (
    input  logic                                      pll_clk1,
    input  logic                                      rst_n,
    input  logic [trigger_target_pkg::ADDR_WIDTH-1:0] usb_addr,
    input  logic [7:0]                                usb_din,
    input  logic                                      usb_rdn,
    input  logic                                      usb_wrn,
    input  logic                                      usb_cen,
    output logic [7:0]                                usb_dout,
    output logic                                      usb_isout,   // Board joins dout/din
    output logic                                      tio_trigger,
    output logic                                      led
);

    trigger_target_pkg::reg_access_t                 access;
    trigger_target_pkg::timer_cmd_t [NUM_TIMERS-1:0] timer_cmd;
    logic [7:0]                                      read_data;
    logic [NUM_TIMERS-1:0]                           fire;
    logic [NUM_TIMERS-1:0]                           status;
    logic [NUM_TIMERS-1:0]                           status_clear;
    logic [NUM_TIMERS-1:0][7:0]                      fire_count;

    host_bus_frontend u_frontend (
        .pll_clk1  (pll_clk1),
        .rst_n     (rst_n),
        .usb_addr  (usb_addr),
        .usb_din   (usb_din),
        .usb_rdn   (usb_rdn),
        .usb_wrn   (usb_wrn),
        .usb_cen   (usb_cen),
        .read_data (read_data),
        .usb_dout  (usb_dout),
        .usb_isout (usb_isout),
        .access    (access)
    );

    trigger_reg_bank #(
        .NUM_TIMERS (NUM_TIMERS)
    ) u_reg_bank (
        .pll_clk1     (pll_clk1),
        .rst_n        (rst_n),
        .access       (access),
        .status       (status),
        .fire_count   (fire_count),
        .read_data    (read_data),
        .timer_cmd    (timer_cmd),
        .status_clear (status_clear)
    );

    for (genvar n = 0; n < NUM_TIMERS; n++) begin : g_timer
        pulse_timer u_timer (
            .pll_clk1 (pll_clk1),
            .rst_n    (rst_n),
            .cmd      (timer_cmd[n]),
            .fire     (fire[n])
        );
    end

    trigger_collector #(
        .NUM_TIMERS (NUM_TIMERS)
    ) u_collector (
        .pll_clk1     (pll_clk1),
        .rst_n        (rst_n),
        .fire         (fire),
        .status_clear (status_clear),
        .status       (status),
        .fire_count   (fire_count),
        .tio_trigger  (tio_trigger),
        .led          (led)
    );

endmodule

//--- verification/tb_host_bus_tasks.svh
// ################################################
// Host bus access tasks
// Parallel bus write and read cycles on the
// active-low strobes
// ################################################
`ifndef TB_HOST_BUS_TASKS_SVH
`define TB_HOST_BUS_TASKS_SVH

localparam int HOLD_CYCLES   = 4;                           // Strobe low time
localparam int IDLE_CYCLES   = 4;                           // Strobe high time after access
localparam int ISOUT_TIMEOUT = 16;                          // Cycles allowed for usb_isout

// Address and data stay stable while cen and wrn are low
task automatic host_write(input logic [31:0] addr, input logic [7:0] data);
    @(posedge pll_clk1);
    usb_addr <= addr;
    usb_din  <= data;
    usb_cen  <= 1'b0;
    usb_wrn  <= 1'b0;
    repeat (HOLD_CYCLES) @(posedge pll_clk1);
    usb_cen <= 1'b1;
    usb_wrn <= 1'b1;
    repeat (IDLE_CYCLES) @(posedge pll_clk1);
endtask

task automatic host_read(input logic [31:0] addr, output logic [7:0] data);
    int waited;
    waited = 0;
    @(posedge pll_clk1);
    usb_addr <= addr;
    usb_cen  <= 1'b0;
    usb_rdn  <= 1'b0;
    @(negedge pll_clk1);
    while (!usb_isout) begin                                // Synchronizer delay
        if (waited == ISOUT_TIMEOUT)
            stop_on_error("host read: usb_isout never went high");
        waited++;
        @(negedge pll_clk1);
    end
    repeat (2) @(negedge pll_clk1);                         // Read strobe, then read_data
    data = usb_dout;
    @(posedge pll_clk1);
    usb_cen <= 1'b1;
    usb_rdn <= 1'b1;
    waited = 0;
    @(negedge pll_clk1);
    while (usb_isout) begin
        if (waited == ISOUT_TIMEOUT)
            stop_on_error("host read: usb_isout stayed high after strobes released");
        waited++;
        @(negedge pll_clk1);
    end
    repeat (IDLE_CYCLES - 1) @(posedge pll_clk1);
endtask

`endif

//--- verification/tb_trigger_target.sv
// ################################################
// Trigger timer target testbench
// Register map model, host bus scenarios and
// read-back comparison
// ################################################
`timescale 1ns/100ps

module tb_trigger_target;

    localparam int NUM_TIMERS = 4;
    localparam int POLL_LIMIT = 200;                        // Status or count polls
    localparam int ID   = trigger_target_pkg::REG_IDENT;
    localparam int STAT = trigger_target_pkg::REG_STATUS;
    localparam int RLD  = trigger_target_pkg::REG_RELOAD_BASE;
    localparam int CTL  = trigger_target_pkg::REG_CTRL_BASE;
    localparam int CNT  = trigger_target_pkg::REG_COUNT_BASE;

    logic        pll_clk1;
    logic        rst_n;
    logic [31:0] usb_addr;
    logic [7:0]  usb_din;
    logic        usb_rdn;
    logic        usb_wrn;
    logic        usb_cen;
    logic [7:0]  usb_dout;
    logic        usb_isout;
    logic        tio_trigger;
    logic        led;

    logic [15:0]           model_reload [NUM_TIMERS];   // Register map model
    logic                  model_mode   [NUM_TIMERS];
    logic [7:0]            model_count  [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] model_status;
    logic [31:0]           lcg_state;
    int                    trig_pulses;                 // tio_trigger pulses seen
    string                 chk_name_q [$];              // Pending compares
    logic [7:0]            chk_exp_q  [$];
    logic [7:0]            chk_act_q  [$];
    string                 cmp_name;
    logic [7:0]            cmp_exp;
    logic [7:0]            cmp_act;

    trigger_target_top #(
        .NUM_TIMERS (NUM_TIMERS)
    ) UUT (
        .pll_clk1    (pll_clk1),
        .rst_n       (rst_n),
        .usb_addr    (usb_addr),
        .usb_din     (usb_din),
        .usb_rdn     (usb_rdn),
        .usb_wrn     (usb_wrn),
        .usb_cen     (usb_cen),
        .usb_dout    (usb_dout),
        .usb_isout   (usb_isout),
        .tio_trigger (tio_trigger),
        .led         (led)
    );

    initial pll_clk1 = 1'b0;
    always #2 pll_clk1 = ~pll_clk1;                         // 4 ns period

    task automatic stop_on_error(input string why);
        $display("SIMULATION FAILED");
        $display("%s", why);
        $fatal(1, "testbench stopped on first error");
    endtask

    `include "tb_host_bus_tasks.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] reg_addr(input int r, input int b);
        return {r[23:0], b[7:0]};                           // Index above byte count
    endfunction

    // Expected read byte from the model
    function automatic logic [7:0] expected_read(input logic [31:0] addr);
        int         r;
        int         b;
        logic [7:0] v;
        r = int'(addr[31:8]);
        b = int'(addr[7:0]);
        v = 8'h00;                                          // Unmapped
        if (r == ID && b == 0)
            v = 8'h5A;
        if (r == STAT && b == 0)
            v = 8'(model_status);
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (r == RLD + n && b < 2)
                v = model_reload[n][8*b +: 8];              // Little endian
            if (r == CTL + n && b == 0)
                v = {5'b00000, model_mode[n], 2'b00};       // Start, stop read 0
            if (r == CNT + n && b == 0)
                v = model_count[n];
        end
        return v;
    endfunction

    function automatic void queue_check(input string name, input logic [7:0] exp,
                                        input logic [7:0] act);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp);
        chk_act_q.push_back(act);
    endfunction

    always @(posedge pll_clk1) begin
        while (chk_exp_q.size() > 0) begin
            cmp_name = chk_name_q.pop_front();
            cmp_exp  = chk_exp_q.pop_front();
            cmp_act  = chk_act_q.pop_front();
            assert (cmp_act === cmp_exp) else
                stop_on_error($sformatf("FAILED time=%0t %s expected=%02h actual=%02h",
                                        $time, cmp_name, cmp_exp, cmp_act));
        end
    end

    always @(posedge pll_clk1 or negedge rst_n) begin
        if (!rst_n)
            trig_pulses <= 0;
        else if (tio_trigger)
            trig_pulses <= trig_pulses + 1;
    end

    // Bus write that keeps the model in step
    task automatic write_reg(input int r, input int b, input logic [7:0] data);
        host_write(reg_addr(r, b), data);
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (r == RLD + n && b < 2)
                model_reload[n][8*b +: 8] = data;
            if (r == CTL + n && b == 0)
                model_mode[n] = data[2];
        end
        if (r == STAT && b == 0)
            model_status = model_status & ~data[NUM_TIMERS-1:0];   // W1C
    endtask

    task automatic check_reg(input string name, input int r, input int b);
        logic [7:0] data;
        host_read(reg_addr(r, b), data);
        queue_check(name, expected_read(reg_addr(r, b)), data);
    endtask

    task automatic check_all();
        check_reg("ident", ID, 0);
        check_reg("status", STAT, 0);
        for (int n = 0; n < NUM_TIMERS; n++) begin
            check_reg($sformatf("reload%0d_lo", n), RLD + n, 0);
            check_reg($sformatf("reload%0d_hi", n), RLD + n, 1);
            check_reg($sformatf("ctrl%0d", n), CTL + n, 0);
            check_reg($sformatf("count%0d", n), CNT + n, 0);
        end
    endtask

    task automatic check_led(input logic exp);
        @(negedge pll_clk1);
        queue_check("led", {7'b0, exp}, {7'b0, led});
    endtask

    task automatic wait_status(input logic [NUM_TIMERS-1:0] mask);
        logic [7:0] data;
        int         polls;
        polls = 0;
        host_read(reg_addr(STAT, 0), data);
        while ((data[NUM_TIMERS-1:0] & mask) != mask) begin
            if (polls == POLL_LIMIT)
                stop_on_error($sformatf("timeout waiting for status bits %b", mask));
            polls++;
            host_read(reg_addr(STAT, 0), data);
        end
    endtask

    initial begin : scenarios
        logic [31:0]           rnd;
        logic [7:0]            data;
        logic [NUM_TIMERS-1:0] mask;
        int                    t;
        int                    p;
        int                    k;
        int                    pulses;
        int                    polls;
        usb_addr  = '0;
        usb_din   = '0;
        usb_rdn   = 1'b1;
        usb_wrn   = 1'b1;
        usb_cen   = 1'b1;
        rst_n     = 1'b0;
        lcg_state = 32'hc246;
        model_status = '0;
        for (int n = 0; n < NUM_TIMERS; n++) begin
            model_reload[n] = '0;
            model_mode[n]   = 1'b0;
            model_count[n]  = '0;
        end
        repeat (5) @(posedge pll_clk1);
        rst_n <= 1'b1;

        check_all();                                        // Reset values
        @(negedge pll_clk1);
        queue_check("tio_trigger", 8'h00, {7'b0, tio_trigger});
        check_led(1'b0);

        for (int n = 0; n < NUM_TIMERS; n++) begin          // Random reloads
            for (int b = 0; b < 2; b++) begin
                rnd = lcg_next();
                write_reg(RLD + n, b, rnd[23:16]);
            end
        end
        check_all();
        check_reg("unmapped_05", 'h05, 0);
        check_reg("unmapped_3f", 'h3F, 0);
        check_reg("ident_b1", ID, 1);
        check_reg("ctrl0_b1", CTL, 1);

        rnd = lcg_next();                                   // Repeated one-shot
        t = int'(rnd[17:16]);
        rnd = lcg_next();
        k = 1 + int'(rnd[23:16]) % 5;
        rnd = lcg_next();
        write_reg(RLD + t, 0, 8'(8 + int'(rnd[20:16])));
        write_reg(RLD + t, 1, 8'h00);
        mask = '0;
        mask[t] = 1'b1;
        for (int i = 0; i < k; i++) begin
            pulses = trig_pulses;
            write_reg(CTL + t, 0, 8'h01);
            wait_status(mask);
            model_status[t] = 1'b1;
            model_count[t]  = model_count[t] + 8'd1;
            assert (trig_pulses > pulses) else
                stop_on_error("tio_trigger did not pulse while waiting for a fire");
            check_reg("status", STAT, 0);
            write_reg(STAT, 0, 8'(mask));
        end
        check_all();

        p = (t + 1) % NUM_TIMERS;                           // Periodic, then stop
        rnd = lcg_next();
        write_reg(RLD + p, 0, 8'(2 + int'(rnd[18:16])));
        write_reg(RLD + p, 1, 8'h00);
        write_reg(CTL + p, 0, 8'h05);
        polls = 0;
        host_read(reg_addr(CNT + p, 0), data);
        while (data <= 8'd2) begin
            if (polls == POLL_LIMIT)
                stop_on_error("timeout waiting for the periodic timer to fire 3 times");
            polls++;
            host_read(reg_addr(CNT + p, 0), data);
        end
        write_reg(CTL + p, 0, 8'h06);                       // Stop, keep mode
        host_read(reg_addr(CNT + p, 0), data);
        assert (data > 8'd2) else
            stop_on_error("periodic fire count dropped after stop");
        model_count[p]  = data;                             // Baseline after stop
        model_status[p] = 1'b1;
        repeat (200) @(posedge pll_clk1);
        check_reg("count_after_stop", CNT + p, 0);
        check_reg("status", STAT, 0);
        check_reg("ctrl_periodic", CTL + p, 0);

        write_reg(CTL + t, 0, 8'h01);                       // Second sticky bit
        wait_status(mask);
        model_status[t] = 1'b1;
        model_count[t]  = model_count[t] + 8'd1;
        check_led(1'b1);
        write_reg(STAT, 0, 8'(1 << p));
        check_reg("status", STAT, 0);
        check_led(1'b1);                                    // Bit t still pending
        write_reg(STAT, 0, 8'(mask));
        check_reg("status", STAT, 0);
        check_led(1'b0);

        rnd = lcg_next();                                   // Timers started together
        mask = NUM_TIMERS'(1 + int'(rnd[19:16]) % 15);
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (mask[n]) begin
                write_reg(RLD + n, 0, 8'(40 + 16 * n));
                write_reg(RLD + n, 1, 8'h00);
            end
        end
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (mask[n])
                write_reg(CTL + n, 0, 8'h01);
        end
        wait_status(mask);
        for (int n = 0; n < NUM_TIMERS; n++) begin
            if (mask[n]) begin
                model_status[n] = 1'b1;
                model_count[n]  = model_count[n] + 8'd1;
            end
        end
        check_all();
        check_led(1'b1);

        repeat (2) @(posedge pll_clk1);                     // Drain compares
        if (chk_exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_on_error("compare queue still held reads at the end of the run");
        end
    end

endmodule
